/* compile.f */
+incdir+design
design/rv_isa_pkg.sv
design/core_pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core_top.sv
tests/tb_clock_gen.sv
tests/core_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_top_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@echo "No failure reported in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/core_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top_tb
    import rv_isa_pkg::*;
();

    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam int RANDOM_COUNT = 60;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic             clk;
    logic             reset = 1'b1;
    logic             imem_ack_n = 1'b1;
    logic [`XLEN-1:0] imem_data = NOP;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic             dmem_we;

    logic [31:0] prog [$];
    logic [31:0] model_regs [32];
    store_t      expected_q [$];
    logic [31:0] next_store_addr = 32'h100;
    integer      seed = 32'h33f2;
    int          error_count = 0;
    int          stores_seen = 0;
    int          sw_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    tb_clock_gen clock_gen_inst (.o_clk(clk));

    core_top core_top_inst (
        .clk          (clk),
        .i_reset      (reset),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .i_imem_ack_n (imem_ack_n),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_we    (dmem_we)
    );

    function automatic logic [31:0] reg_instr(input logic [6:0] f7, input logic [2:0] f3,
                                              input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] imm_instr(input logic [2:0] f3, input int rd,
                                              input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] store_instr(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] upper_instr(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << sh;
            F3_SLT:     return (a[31] != b[31]) ? {31'd0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: begin
                if (alt) begin
                    return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
                end
                return a >> sh;
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // Architectural effect of one instruction on the model state
    function automatic void apply_reference(input logic [31:0] instr);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic        alt;
        store_t      st;
        opc   = instr[6:0];
        f3    = instr[14:12];
        rd    = instr[11:7];
        a     = model_regs[instr[19:15]];
        b     = model_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        alt   = (opc == OPC_OP || f3 == F3_SRL_SRA) && instr[30];
        case (opc)
            OPC_LUI:    model_regs[rd] = {instr[31:12], 12'h000};
            OPC_OP_IMM: model_regs[rd] = alu_ref(f3, alt, a, imm_i);
            OPC_OP:     model_regs[rd] = alu_ref(f3, alt, a, b);
            OPC_STORE: begin
                st.addr = a + imm_s;
                st.data = b;
                expected_q.push_back(st);
            end
            default: ;
        endcase
        model_regs[0] = '0;
    endfunction

    task automatic emit(input logic [31:0] instr);
        prog.push_back(instr);
        apply_reference(instr);
        if (instr[6:0] == OPC_STORE) begin
            sw_count++;
        end
    endtask

    task automatic store_reg(input int r);
        emit(store_instr(r, 0, int'(next_store_addr)));
        next_store_addr += 4;
    endtask

    task automatic store_regs();
        for (int r = 1; r <= 7; r++) begin
            store_reg(r);
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] val;
        logic [2:0]  f3;
        int          imm;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        // Immediate group with negative operands
        emit(upper_instr(1, 'h80000));
        emit(imm_instr(F3_ADD_SUB, 2, 0, -5));
        emit(imm_instr(F3_SLT, 3, 2, -4));
        emit(imm_instr(F3_SLTU, 4, 2, 3));
        emit(imm_instr(F3_XOR, 5, 2, 'h7ff));
        emit(imm_instr(F3_OR, 6, 1, 'h123));
        emit(imm_instr(F3_AND, 7, 2, 'h0f0));
        store_regs();
        emit(imm_instr(F3_SLL, 3, 2, 4));
        emit(imm_instr(F3_SRL_SRA, 4, 1, 7));
        emit(imm_instr(F3_SRL_SRA, 5, 1, 'h400 | 9));
        emit(imm_instr(F3_SRL_SRA, 6, 3, 'h400 | 1));
        emit(imm_instr(F3_SLTU, 7, 2, -1));
        store_regs();
        // Register group with x3 = 37 so only the low five bits shift
        emit(imm_instr(F3_ADD_SUB, 3, 0, 37));
        emit(reg_instr(F7_BASE, F3_SLL, 4, 2, 3));
        emit(reg_instr(F7_BASE, F3_SRL_SRA, 5, 1, 3));
        emit(reg_instr(F7_ALT, F3_SRL_SRA, 6, 1, 3));
        emit(reg_instr(F7_ALT, F3_ADD_SUB, 7, 2, 1));
        emit(reg_instr(F7_BASE, F3_ADD_SUB, 1, 7, 6));
        emit(reg_instr(F7_BASE, F3_SLT, 2, 1, 4));
        emit(reg_instr(F7_BASE, F3_SLTU, 3, 1, 4));
        emit(reg_instr(F7_BASE, F3_XOR, 4, 1, 2));
        emit(reg_instr(F7_BASE, F3_OR, 5, 4, 3));
        emit(reg_instr(F7_BASE, F3_AND, 6, 5, 1));
        // x0 written and then read straight away
        emit(imm_instr(F3_ADD_SUB, 0, 0, 99));
        emit(reg_instr(F7_BASE, F3_ADD_SUB, 0, 1, 2));
        emit(reg_instr(F7_BASE, F3_OR, 7, 0, 0));
        store_reg(0);
        store_regs();
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            r   = $random(seed);
            val = $random(seed);
            f3  = r[4:2];
            if (r[1:0] == 2'd0) begin
                emit(upper_instr(int'(r[7:5]), int'(val[19:0])));
            end else if (r[1:0] == 2'd1) begin
                imm = int'(val[11:0]);
                if (f3 == F3_SLL) begin
                    imm = int'(val[4:0]);
                end else if (f3 == F3_SRL_SRA) begin
                    imm = int'(val[4:0]) | (r[14] ? 'h400 : 0);
                end
                emit(imm_instr(f3, int'(r[7:5]), int'(r[10:8]), imm));
            end else begin
                emit(reg_instr((r[14] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ?
                               F7_ALT : F7_BASE, f3, int'(r[7:5]), int'(r[10:8]),
                               int'(r[13:11])));
            end
        end
        store_regs();
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ((addr >> 2) < prog.size()) begin
            return prog[addr >> 2];
        end
        return NOP;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Memory answers for the current PC and drops ack about one cycle in four
    always @(negedge clk) begin
        imem_data <= fetch_word(imem_addr);
        if (reset) begin
            imem_ack_n <= 1'b1;
        end else begin
            imem_ack_n <= ($random(seed) & 3) == 0;
        end
    end

    always @(negedge clk) begin
        store_t exp;
        if (reset) begin
            if (dmem_we === 1'b1) begin
                $display("Store strobe was high during reset at %0t ns", $time);
                error_count++;
            end
        end else if (dmem_we) begin
            stores_seen++;
            if (expected_q.size() == 0) begin
                $display("Unexpected store to %h with data %h at %0t ns",
                         dmem_addr, dmem_wdata, $time);
                error_count++;
            end else begin
                exp = expected_q.pop_front();
                check_value($sformatf("store %0d address", stores_seen), dmem_addr, exp.addr);
                check_value($sformatf("store %0d data", stores_seen), dmem_wdata, exp.data);
            end
        end else begin
            check_value("idle store address", dmem_addr, 32'h0);
            check_value("idle store data", dmem_wdata, 32'h0);
        end
    end

    initial begin
        build_program();
        cycle_limit = 4 * prog.size() + 100;
        repeat (10) @(negedge clk);
        reset <= 1'b0;
        check_value("PC after reset", imem_addr, `RESET_PC);
        while (stores_seen < sw_count && cycle_count < cycle_limit) begin
            @(negedge clk);
        end
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycle_count, stores_seen, sw_count);
            error_count++;
        end else begin
            // Drain so that any extra store still shows up
            repeat (10) @(negedge clk);
        end
        if (expected_q.size() != 0) begin
            $display("%0d expected stores never appeared", expected_q.size());
            error_count++;
        end
        if (stores_seen != sw_count) begin
            $display("Saw %0d stores but the program has %0d SW instructions",
                     stores_seen, sw_count);
            error_count++;
        end
        $display("Done: %0d errors, %0d stores seen, %0d expected, %0d cycles",
                 error_count, stores_seen, sw_count, cycle_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* design/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top
    import core_pipe_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             i_reset,

    // Instruction bus
    output logic [`XLEN-1:0]      o_imem_addr,
    input  wire logic [`XLEN-1:0] i_imem_data,
    input  wire logic             i_imem_ack_n,

    // Data bus, stores only
    output logic [`XLEN-1:0]      o_dmem_addr,
    output logic [`XLEN-1:0]      o_dmem_wdata,
    output logic                  o_dmem_we
);

    reg_idx_t         rs1;
    reg_idx_t         rs2;
    logic [`XLEN-1:0] rs1_value;
    logic [`XLEN-1:0] rs2_value;
    decoded_op_t      decoded;
    exec_result_t     result;
    reg_write_t       write;

    decode_stage decode_stage_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_imem_data  (i_imem_data),
        .i_imem_ack_n (i_imem_ack_n),
        .o_imem_addr  (o_imem_addr),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .i_rs1_value  (rs1_value),
        .i_rs2_value  (rs2_value),
        .o_decoded    (decoded)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_decoded (decoded),
        .o_result  (result)
    );

    result_stage result_stage_inst (
        .i_result     (result),
        .o_write      (write),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we)
    );

    reg_file reg_file_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_rs1       (rs1),
        .i_rs2       (rs2),
        .i_write     (write),
        .o_rs1_value (rs1_value),
        .o_rs2_value (rs2_value)
    );

endmodule

`default_nettype wire

/* design/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module result_stage
    import core_pipe_pkg::*;
(
    input  wire exec_result_t i_result,
    output reg_write_t        o_write,
    output logic [`XLEN-1:0]  o_dmem_addr,
    output logic [`XLEN-1:0]  o_dmem_wdata,
    output logic              o_dmem_we
);

    logic store_fire;

    assign store_fire = i_result.valid && i_result.store;

    always_comb begin
        o_write.enable = i_result.valid && i_result.reg_write;
        o_write.rd     = i_result.rd;
        o_write.data   = i_result.result;
    end

    // Bus idles at zero between stores
    assign o_dmem_we    = store_fire;
    assign o_dmem_addr  = store_fire ? i_result.result : '0;
    assign o_dmem_wdata = store_fire ? i_result.store_data : '0;

    // Store and write-back come from exclusive decode paths
    always_comb begin
        a_store_xor_write: assert (!(o_dmem_we && o_write.enable))
            else $error("store strobe and register write active together");
    end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_stage
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        i_reset,
    input  wire decoded_op_t i_decoded,
    output exec_result_t     o_result
);

    logic             fwd_ok;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_out;
    exec_result_t     res;

    // Previous instruction still sits in our own output register
    assign fwd_ok = o_result.valid && o_result.reg_write && o_result.rd != '0;

    always_comb begin
        op_a = i_decoded.rs1_value;
        if (fwd_ok && o_result.rd == i_decoded.rs1) begin
            op_a = o_result.result;
        end
        rs2_fwd = i_decoded.rs2_value;
        if (fwd_ok && o_result.rd == i_decoded.rs2) begin
            rs2_fwd = o_result.result;
        end
        op_b = i_decoded.use_imm ? i_decoded.imm : rs2_fwd;
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (i_decoded.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = `XLEN'(op_a < op_b);
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        res.valid      = i_decoded.valid;
        res.rd         = i_decoded.rd;
        res.reg_write  = i_decoded.reg_write;
        res.store      = i_decoded.store;
        res.result     = alu_out;
        res.store_data = rs2_fwd;
    end

    always_ff @(posedge clk) begin
        o_result <= res;
        if (i_reset) begin
            o_result.valid <= 1'b0;
        end
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (i_reset)
        (o_result.valid && o_result.reg_write) |-> o_result.rd != '0);

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode_stage
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  wire logic [`XLEN-1:0] i_imem_data,
    input  wire logic             i_imem_ack_n,
    output logic [`XLEN-1:0]      o_imem_addr,
    output reg_idx_t              o_rs1,
    output reg_idx_t              o_rs2,
    input  wire logic [`XLEN-1:0] i_rs1_value,
    input  wire logic [`XLEN-1:0] i_rs2_value,
    output decoded_op_t           o_decoded
);

    logic             accept;
    logic [`XLEN-1:0] pc_q;
    opcode_t          opcode;
    funct3_t          funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;
    decoded_op_t      dec;

    function automatic alu_op_t base_alu_op(input funct3_t f3);
        case (f3)
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    assign accept      = !i_imem_ack_n;
    assign o_imem_addr = pc_q;
    assign o_rs1       = i_imem_data[19:15];
    assign o_rs2       = i_imem_data[24:20];
    assign opcode      = opcode_t'(i_imem_data[6:0]);
    assign funct3      = funct3_t'(i_imem_data[14:12]);
    assign funct7      = i_imem_data[31:25];

    assign imm_i = {{(`XLEN-12){i_imem_data[31]}}, i_imem_data[31:20]};
    assign imm_s = {{(`XLEN-12){i_imem_data[31]}}, i_imem_data[31:25], i_imem_data[11:7]};
    assign imm_u = {i_imem_data[31:12], 12'b0};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc_q <= `RESET_PC;
        end else if (accept) begin
            pc_q <= pc_q + `XLEN'(4);
        end
    end

    always_comb begin
        dec           = '0;
        dec.rs1       = o_rs1;
        dec.rs2       = o_rs2;
        dec.rd        = i_imem_data[11:7];
        dec.rs1_value = i_rs1_value;
        dec.rs2_value = i_rs2_value;
        case (opcode)
            OPC_LUI: begin
                dec.valid     = 1'b1;
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.use_imm   = 1'b1;
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
                dec.alu_op    = base_alu_op(funct3);
                dec.valid     = 1'b1;
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == F3_SLL) begin
                    dec.valid = (funct7 == F7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    dec.valid = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    if (funct7 == F7_ALT) begin
                        dec.alu_op = ALU_SRA;
                    end
                end
            end
            OPC_OP: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = base_alu_op(funct3);
                if (funct7 == F7_BASE) begin
                    dec.valid = 1'b1;
                end else if (funct7 == F7_ALT) begin
                    dec.valid  = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
                    dec.alu_op = (funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                end
            end
            OPC_STORE: begin
                dec.valid   = (funct3 == F3_SW);
                dec.alu_op  = ALU_ADD;
                dec.use_imm = 1'b1;
                dec.imm     = imm_s;
                dec.store   = 1'b1;
            end
            default: begin
                dec.valid = 1'b0;
            end
        endcase
        // x0 is never a real destination
        if (dec.rd == '0) begin
            dec.reg_write = 1'b0;
        end
        // Bubble while the memory holds off
        if (!accept) begin
            dec.valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        o_decoded <= dec;
        if (i_reset) begin
            o_decoded.valid <= 1'b0;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (i_reset)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module reg_file
    import core_pipe_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  wire reg_idx_t         i_rs1,
    input  wire reg_idx_t         i_rs2,
    input  wire reg_write_t       i_write,
    output logic [`XLEN-1:0]      o_rs1_value,
    output logic [`XLEN-1:0]      o_rs2_value
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // Same-cycle write is visible to the reader
    function automatic logic [`XLEN-1:0] read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_write.enable && i_write.rd == idx) begin
            return i_write.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write.enable && i_write.rd != '0) begin
            regs[i_write.rd] <= i_write.data;
        end
    end

    always_comb begin
        o_rs1_value = read_port(i_rs1);
        o_rs2_value = read_port(i_rs2);
    end

    a_x0_stays_zero: assert property (@(posedge clk) disable iff (i_reset)
        (i_write.enable && i_write.rd == '0) |->
            (i_rs1 != '0 || o_rs1_value == '0) && (i_rs2 != '0 || o_rs2_value == '0));

endmodule

`default_nettype wire

/* design/core_pipe_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package core_pipe_pkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // Decode to execute
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::alu_op_t  alu_op;
        reg_idx_t             rs1;
        reg_idx_t             rs2;
        reg_idx_t             rd;
        logic                 use_imm;
        logic [`XLEN-1:0]     imm;
        logic                 reg_write;
        logic                 store;
        logic [`XLEN-1:0]     rs1_value;
        logic [`XLEN-1:0]     rs2_value;
    } decoded_op_t;

    // Execute to result, result doubles as store address
    typedef struct packed {
        logic             valid;
        reg_idx_t         rd;
        logic             reg_write;
        logic             store;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] store_data;
    } exec_result_t;

    typedef struct packed {
        logic             enable;
        reg_idx_t         rd;
        logic [`XLEN-1:0] data;
    } reg_write_t;

endpackage

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    // Store width code for a full word
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        // LUI passes the immediate through
        ALU_PASS_B
    } alu_op_t;

endpackage

`default_nettype wire

/* design/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
